/* src.f */
hdl/chan_data_pkg.sv
hdl/chan_cmd_pkg.sv
hdl/cmd_ctrl.sv
hdl/fill_store.sv
hdl/burst_narrow.sv
hdl/tx_select.sv
hdl/chan_readout_top.sv
test/chan_readout_sva.sv
test/tb_chan_readout.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_chan_readout \
	-f src.f -Mdir obj_dir > build.log 2>&1 \
	&& { ./obj_dir/Vtb_chan_readout > sim.log 2>&1 || true; } \
	&& grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* test/tb_chan_readout.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_chan_readout;

	import chan_data_pkg::*;
	import chan_cmd_pkg::*;

	localparam int WAIT_LIMIT = 4000;  // cycles allowed per wait loop

	logic        clk125;
	logic        rst_n;
	burst_t      acq_beat;
	logic        acq_valid;
	logic        acq_ready;
	logic [31:0] cmd_data;     // cmd_word_t on the DUT side
	logic        cmd_valid;
	logic        cmd_ready;
	link_beat_t  tx_beat;
	logic        tx_valid;
	logic        tx_ready = 1'b1;
	logic        pause    = 1'b0;

	logic [31:0] rng       = 32'hd13c_8fb6;
	burst_t      store_model [STORE_DEPTH];  // bursts the store should hold
	int          stored_n  = 0;
	link_beat_t  exp_q [$];                  // expected tx beats in arrival order
	int          errors    = 0;
	int          checked   = 0;
	int          tests     = 0;
	logic        timed_out = 1'b0;
	logic        noisy     = 1'b0;           // random tx_ready and pause

	chan_readout_top DUT (.*);

	initial begin
		clk125 = 1'b0;
		forever #20 clk125 = ~clk125;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model builds the expected beats from the command rules
	task automatic expect_word(input logic [3:0] op, input logic [15:0] value,
			input logic last);
		link_beat_t b;
		b.data = {op, 12'h000, value};  // info field always zero
		b.last = last;
		exp_q.push_back(b);
	endtask

	task automatic expect_fill(input int start, input int count);
		link_beat_t b;
		expect_word(CMD_RD_FILL, 16'(count), 1'b0);  // header word with data to follow
		for (int i = start; i < start + count; i++) begin
			for (int w = 0; w < WORDS_PER_BURST; w++) begin
				b.data = store_model[i][w*WORD_W +: WORD_W];  // lsw first
				b.last = (i == start + count - 1) && (w == WORDS_PER_BURST - 1);
				exp_q.push_back(b);
			end
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
		errors++;
	endtask

	// all drivers below start and end on a falling edge
	task automatic send_cmd(input logic [31:0] word);
		int t;
		t = 0;
		if (timed_out) return;
		cmd_data  = word;
		cmd_valid = 1'b1;
		while (!cmd_ready && t < WAIT_LIMIT) begin
			@(negedge clk125);
			t++;
		end
		if (!cmd_ready)
			note_timeout("cmd_ready never came back for a command");
		@(negedge clk125);  // word taken on the rising edge between
		cmd_valid = 1'b0;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		if (timed_out) return;
		while (!(exp_q.size() == 0 && cmd_ready) && t < WAIT_LIMIT) begin
			@(negedge clk125);
			t++;
		end
		if (exp_q.size() != 0 || !cmd_ready)
			note_timeout("expected tx beats never all arrived");
	endtask

	task automatic run_cmd(input logic [31:0] word);
		send_cmd(word);
		wait_idle();
	endtask

	task automatic write_bursts(input int n);
		burst_t b;
		int     t;
		for (int i = 0; i < n && !timed_out; i++) begin
			b = {next_rand(), next_rand(), next_rand(), next_rand()};
			acq_beat  = b;
			acq_valid = 1'b1;
			t = 0;
			while (!acq_ready && t < WAIT_LIMIT) begin
				@(negedge clk125);
				t++;
			end
			if (!acq_ready) begin
				note_timeout("acq_ready stayed low while writing bursts");
			end else begin
				@(negedge clk125);  // burst written on the rising edge
				store_model[stored_n] = b;
				stored_n++;
			end
		end
		acq_valid = 1'b0;
	endtask

	task automatic report_test(input string name, input int mark);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == mark) ? "ok" : "failed");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tx monitor checks every accepted beat against the head of the queue
	always @(posedge clk125) begin : tx_check
		link_beat_t want;
		if (rst_n && tx_valid && tx_ready) begin
			if (exp_q.size() == 0) begin
				$display("tx beat %h arrived when no beat was expected", tx_beat);
				errors++;
			end else begin
				want = exp_q.pop_front();
				checked++;
				assert (tx_beat.data == want.data) else begin
					$display("Error: tx_beat.data is %h, expected %h",
						tx_beat.data, want.data);
					errors++;
				end
				assert (tx_beat.last == want.last) else begin
					$display("Error: tx_beat.last is %h, expected %h",
						tx_beat.last, want.last);
					errors++;
				end
			end
		end
	end

	// link side noise drives tx_ready and pause
	always @(negedge clk125) begin : link_noise
		logic [31:0] r;
		if (noisy) begin
			r = next_rand();
			tx_ready = (r[1:0] != 2'b00);  // ready three beats in four
			if (r[11:8] == 4'h0)
				pause = !pause;             // long random pause periods
		end else begin
			tx_ready = 1'b1;
			pause    = 1'b0;
		end
	end

	initial begin : main
		logic [15:0] tag;
		int          mark;
		acq_beat  = '0;
		acq_valid = 1'b0;
		cmd_data  = '0;
		cmd_valid = 1'b0;
		rst_n     = 1'b0;
		repeat (2) @(posedge clk125);  // reset held two cycles
		@(negedge clk125);
		rst_n = 1'b1;

		mark = errors;
		tag  = 16'(next_rand());
		expect_word(CMD_RD_TAG, TAG_RESET, 1'b1);
		run_cmd({CMD_RD_TAG, 28'h0});
		expect_word(CMD_WR_TAG, tag, 1'b1);  // write echoes the new tag
		run_cmd({CMD_WR_TAG, 12'h000, tag});
		expect_word(CMD_RD_TAG, tag, 1'b1);
		run_cmd({CMD_RD_TAG, 28'h0});
		report_test("tag write and read", mark);

		mark = errors;
		write_bursts(24);
		expect_word(CMD_RD_COUNT, 16'(stored_n), 1'b1);
		run_cmd({CMD_RD_COUNT, 28'h0});
		report_test("stored burst count", mark);

		mark = errors;
		expect_fill(5, 6);
		run_cmd({CMD_RD_FILL, 12'h000, 8'd5, 8'd6});
		report_test("fill read", mark);

		mark = errors;
		expect_word(CMD_BAD, 16'h0, 1'b1);  // zero count
		run_cmd({CMD_RD_FILL, 12'h000, 8'd2, 8'd0});
		expect_word(CMD_BAD, 16'h0, 1'b1);  // 20 + 8 runs past 24 stored
		run_cmd({CMD_RD_FILL, 12'h000, 8'd20, 8'd8});
		expect_word(CMD_BAD, 16'h0, 1'b1);  // undefined opcode
		run_cmd({4'h9, 28'h0});
		report_test("rejected requests", mark);

		mark = errors;
		write_bursts(STORE_DEPTH - stored_n);  // store now full
		@(posedge clk125);
		noisy = 1'b1;  // noise flag flips between falling edges
		@(negedge clk125);
		expect_fill(0, stored_n);
		run_cmd({CMD_RD_FILL, 12'h000, 8'd0, 8'(stored_n)});
		@(posedge clk125);
		noisy = 1'b0;
		@(negedge clk125);
		report_test("full fill under stall and pause", mark);

		$display("tests %0d, tx beats checked %0d, errors %0d", tests, checked,
			errors + DUT.u_sva.fail_count);
		if (errors == 0 && DUT.u_sva.fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/chan_readout_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module chan_readout_sva (
	input wire logic                      clk125,
	input wire logic                      rst_n,
	input wire logic                      acq_ready,
	input wire chan_data_pkg::link_beat_t tx_beat,
	input wire logic                      tx_valid,
	input wire logic                      tx_ready,
	input wire logic                      pause
);

	int fail_count = 0;  // assertion failures seen so far

	// stalled beat stays put, unless the synchronized pause pulled valid low
	// pause reaches tx_valid two edges late, hence $past(pause, 2)
	tx_hold: assert property (@(posedge clk125) disable iff (!rst_n)
		(tx_valid && !tx_ready) |=> ($past(pause, 2) || (tx_valid && $stable(tx_beat))))
	else begin
		$error("tx beat changed or dropped while stalled");
		fail_count++;
	end

	// outputs quiet in the first cycles out of reset
	reset_quiet: assert property (@(posedge clk125)
		$rose(rst_n) |-> (!tx_valid && !acq_ready))
	else begin
		$error("tx_valid or acq_ready high right after reset");
		fail_count++;
	end

	reset_quiet_next: assert property (@(posedge clk125) $rose(rst_n) |=> !tx_valid)
	else begin
		$error("tx_valid high one cycle after reset");
		fail_count++;
	end

	pause_block: assert property (@(posedge clk125) disable iff (!rst_n)
		(pause && $past(pause) && $past(pause, 2)) |-> !tx_valid)
	else begin
		$error("tx_valid high while pause held for three cycles");
		fail_count++;
	end

endmodule

bind chan_readout_top chan_readout_sva u_sva (
	.clk125    (clk125),
	.rst_n     (rst_n),
	.acq_ready (acq_ready),
	.tx_beat   (tx_beat),
	.tx_valid  (tx_valid),
	.tx_ready  (tx_ready),
	.pause     (pause)
);

`default_nettype wire

/* hdl/chan_readout_top.sv */
`timescale 1ns/100ps
`default_nettype none

module chan_readout_top (
	input  wire logic                     clk125,
	input  wire logic                     rst_n,
	input  wire chan_data_pkg::burst_t    acq_beat,    // acquisition stream
	input  wire logic                     acq_valid,
	output logic                          acq_ready,
	input  wire chan_cmd_pkg::cmd_word_t  cmd_data,    // receive stream
	input  wire logic                     cmd_valid,
	output logic                          cmd_ready,
	output chan_data_pkg::link_beat_t     tx_beat,     // transmit stream
	output logic                          tx_valid,
	input  wire logic                     tx_ready,
	input  wire logic                     pause
);

	import chan_data_pkg::*;

	rd_req_t         rd_req;
	logic            rd_start;
	logic [ADDR_W:0] stored_count;
	burst_beat_t     store_beat;  // store to narrowing stage
	logic            store_valid;
	logic            store_ready;
	link_beat_t      fill_beat;   // narrowed fill words
	logic            fill_valid;
	logic            fill_ready;
	link_beat_t      rsp_beat;    // controller replies
	logic            rsp_valid;
	logic            rsp_ready;
	logic            use_fill;
	logic            fill_accept;
	logic            fill_last_accept;

	////////////////////////////////////////////////////////////////////////////
	// command side
	cmd_ctrl u_cmd_ctrl (.clk125, .rst_n, .cmd_data, .cmd_valid, .cmd_ready,
		.rsp_beat, .rsp_valid, .rsp_ready, .rd_req, .rd_start, .use_fill,
		.fill_accept, .fill_last_accept, .stored_count);

	////////////////////////////////////////////////////////////////////////////
	// data path, store then 128 to 32 narrowing then link select
	fill_store u_fill_store (.clk125, .rst_n, .acq_beat, .acq_valid, .acq_ready,
		.rd_req, .rd_start, .out_beat(store_beat), .out_valid(store_valid),
		.out_ready(store_ready), .stored_count);

	burst_narrow u_burst_narrow (.clk125, .rst_n, .in_beat(store_beat),
		.in_valid(store_valid), .in_ready(store_ready), .out_beat(fill_beat),
		.out_valid(fill_valid), .out_ready(fill_ready));

	tx_select u_tx_select (.clk125, .rst_n, .pause, .use_fill, .rsp_beat,
		.rsp_valid, .rsp_ready, .fill_beat, .fill_valid, .fill_ready, .tx_beat,
		.tx_valid, .tx_ready, .fill_accept, .fill_last_accept);

endmodule

`default_nettype wire

/* hdl/tx_select.sv */
`timescale 1ns/100ps
`default_nettype none

module tx_select (
	input  wire logic                       clk125,
	input  wire logic                       rst_n,
	input  wire logic                       pause,       // asynchronous
	input  wire logic                       use_fill,
	input  wire chan_data_pkg::link_beat_t  rsp_beat,
	input  wire logic                       rsp_valid,
	output logic                            rsp_ready,
	input  wire chan_data_pkg::link_beat_t  fill_beat,
	input  wire logic                       fill_valid,
	output logic                            fill_ready,
	output chan_data_pkg::link_beat_t       tx_beat,
	output logic                            tx_valid,
	input  wire logic                       tx_ready,
	output logic                            fill_accept,
	output logic                            fill_last_accept
);

	logic pause_meta;
	logic pause_sync;  // two edges behind the pin

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			pause_meta <= 1'b0;
			pause_sync <= 1'b0;
		end else begin
			pause_meta <= pause;
			pause_sync <= pause_meta;
		end
	end

	// 2:1 mux, fill data only while the controller hands it the link
	assign tx_beat  = use_fill ? fill_beat : rsp_beat;
	assign tx_valid = (use_fill ? fill_valid : rsp_valid) && !pause_sync;

	// ready to the active source only, held off during pause so beats stay put
	assign rsp_ready  = !use_fill && tx_ready && !pause_sync;
	assign fill_ready =  use_fill && tx_ready && !pause_sync;

	assign fill_accept      = use_fill && tx_valid && tx_ready;
	assign fill_last_accept = fill_accept && fill_beat.last;  // end of the fill

endmodule

`default_nettype wire

/* hdl/burst_narrow.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_narrow (
	input  wire logic                        clk125,
	input  wire logic                        rst_n,
	input  wire chan_data_pkg::burst_beat_t  in_beat,
	input  wire logic                        in_valid,
	output logic                             in_ready,
	output chan_data_pkg::link_beat_t        out_beat,
	output logic                             out_valid,
	input  wire logic                        out_ready
);

	import chan_data_pkg::*;

	localparam int IDX_W = $clog2(WORDS_PER_BURST);

	burst_beat_t      hold;      // burst being sent out
	logic             full;
	logic [IDX_W-1:0] idx;       // word now on out_beat
	logic             word_end;  // last word of the held burst

	assign word_end  = (idx == IDX_W'(WORDS_PER_BURST - 1));
	assign out_valid = full;
	assign out_beat.data = hold.data[idx*WORD_W +: WORD_W];  // lsw first
	assign out_beat.last = hold.last && word_end;             // only on word three
	assign in_ready  = !full || (out_ready && word_end);      // refill as word three leaves

	always_ff @(posedge clk125) begin
		if (in_valid && in_ready)
			hold <= in_beat;
	end

	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			full <= 1'b0;
			idx  <= '0;
		end else begin
			if (out_valid && out_ready) begin
				idx <= idx + 1'b1;  // wraps to zero after word three
				if (word_end)
					full <= 1'b0;
			end
			if (in_valid && in_ready)
				full <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/fill_store.sv */
`timescale 1ns/100ps
`default_nettype none

module fill_store (
	input  wire logic                      clk125,
	input  wire logic                      rst_n,
	input  wire chan_data_pkg::burst_t     acq_beat,
	input  wire logic                      acq_valid,
	output logic                           acq_ready,
	input  wire chan_data_pkg::rd_req_t    rd_req,
	input  wire logic                      rd_start,
	output chan_data_pkg::burst_beat_t     out_beat,
	output logic                           out_valid,
	input  wire logic                      out_ready,
	output logic [chan_data_pkg::ADDR_W:0] stored_count
);

	import chan_data_pkg::*;

	burst_t            mem [STORE_DEPTH];
	logic              run;
	logic [ADDR_W:0]   wr_ptr;      // bursts written so far
	logic [ADDR_W-1:0] rd_addr;     // next burst to fetch
	logic [ADDR_W:0]   issue_left;  // fetches still to issue
	burst_t            rd_q;        // memory read register
	logic              q_last;
	logic              q_valid;     // rd_q holds a fetched burst
	logic              q_move;
	logic              issue;
	logic              rd_busy;

	assign stored_count = wr_ptr;
	assign rd_busy      = rd_start || (issue_left != '0) || q_valid || out_valid;
	assign acq_ready    = run && (wr_ptr != STORE_DEPTH) && !rd_busy;  // no writes mid-read

	assign q_move = q_valid && (!out_valid || out_ready);    // rd_q into skid register
	assign issue  = (issue_left != '0) && (!q_valid || q_move);

	////////////////////////////////////////////////////////////////////////////
	// burst memory with sequential write and registered read
	always_ff @(posedge clk125) begin
		if (acq_valid && acq_ready)
			mem[wr_ptr[ADDR_W-1:0]] <= acq_beat;
		if (issue) begin
			rd_q   <= mem[rd_addr];             // data one cycle after the address
			q_last <= (issue_left == 7'd1);     // final burst of this read
		end
		if (q_move) begin
			out_beat.data <= rd_q;
			out_beat.last <= q_last;
		end
	end

	// write pointer and read engine control
	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			run        <= 1'b0;
			wr_ptr     <= '0;
			rd_addr    <= '0;
			issue_left <= '0;
			q_valid    <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			run <= 1'b1;
			if (acq_valid && acq_ready)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_start) begin
				rd_addr    <= rd_req.start[ADDR_W-1:0];
				issue_left <= rd_req.count;
			end else if (issue) begin
				rd_addr    <= rd_addr + 1'b1;
				issue_left <= issue_left - 1'b1;
			end
			if (issue)
				q_valid <= 1'b1;
			else if (q_move)
				q_valid <= 1'b0;
			if (q_move)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/cmd_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_ctrl (
	input  wire logic                       clk125,
	input  wire logic                       rst_n,
	input  wire chan_cmd_pkg::cmd_word_t    cmd_data,
	input  wire logic                       cmd_valid,
	output logic                            cmd_ready,
	output chan_data_pkg::link_beat_t       rsp_beat,
	output logic                            rsp_valid,
	input  wire logic                       rsp_ready,
	output chan_data_pkg::rd_req_t          rd_req,
	output logic                            rd_start,
	output logic                            use_fill,
	input  wire logic                       fill_accept,
	input  wire logic                       fill_last_accept,
	input  wire logic [chan_data_pkg::ADDR_W:0] stored_count
);

	import chan_data_pkg::*;
	import chan_cmd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,    // waiting for a command
		ST_REPLY,   // single-word reply pending on tx
		ST_HEADER,  // fill header pending on tx
		ST_FILL     // fill data owns the tx stream
	} state_e;

	state_e      state;
	state_e      dec_state;
	logic        run;          // low for the first cycle out of reset
	logic [15:0] tag;
	logic        cmd_take;
	logic [7:0]  fill_start;
	logic [7:0]  fill_count;
	logic [8:0]  fill_end;     // start + count, one bit of headroom
	logic        fill_ok;
	rsp_word_t   dec_word;
	logic        dec_last;

	assign cmd_ready = run && (state == ST_IDLE);  // one command in flight
	assign cmd_take  = cmd_valid && cmd_ready;

	assign fill_start = cmd_data.arg[15:8];
	assign fill_count = cmd_data.arg[7:0];
	assign fill_end   = {1'b0, fill_start} + {1'b0, fill_count};
	assign fill_ok    = (fill_count != 8'd0) && (fill_end <= 9'(stored_count));

	////////////////////////////////////////////////////////////////////////////
	// command decode, builds the reply word for the command on cmd_data
	always_comb begin
		dec_word.op    = CMD_BAD;
		dec_word.info  = '0;
		dec_word.value = '0;
		dec_last       = 1'b1;  // single-word replies end here
		dec_state      = ST_REPLY;
		case (cmd_data.op)
			CMD_WR_TAG: begin
				dec_word.op    = CMD_WR_TAG;
				dec_word.value = cmd_data.arg;   // echo the tag just written
			end
			CMD_RD_TAG: begin
				dec_word.op    = CMD_RD_TAG;
				dec_word.value = tag;
			end
			CMD_RD_COUNT: begin
				dec_word.op    = CMD_RD_COUNT;
				dec_word.value = 16'(stored_count);
			end
			CMD_RD_FILL: if (fill_ok) begin
				dec_word.op    = CMD_RD_FILL;
				dec_word.value = 16'(fill_count);  // header carries the burst count
				dec_last       = 1'b0;             // data words follow
				dec_state      = ST_HEADER;
			end
			default: ;  // undefined opcode gets CMD_BAD
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// control FSM
	always_ff @(posedge clk125) begin
		if (!rst_n) begin
			run       <= 1'b0;
			state     <= ST_IDLE;
			rsp_valid <= 1'b0;
			rd_start  <= 1'b0;
			use_fill  <= 1'b0;
			tag       <= TAG_RESET;
		end else begin
			run      <= 1'b1;
			rd_start <= 1'b0;  // one-cycle pulse
			case (state)
				ST_IDLE: if (cmd_take) begin
					rsp_valid <= 1'b1;
					state     <= dec_state;
					if (cmd_data.op == CMD_WR_TAG)
						tag <= cmd_data.arg;
				end
				ST_REPLY: if (rsp_ready) begin  // rsp_valid is high here
					rsp_valid <= 1'b0;
					state     <= ST_IDLE;
				end
				ST_HEADER: if (rsp_ready) begin
					rsp_valid <= 1'b0;
					rd_start  <= 1'b1;  // kick the store read engine
					use_fill  <= 1'b1;  // hand tx to the fill path
					state     <= ST_FILL;
				end
				ST_FILL: if (fill_accept && fill_last_accept) begin
					use_fill <= 1'b0;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// reply word and read request latched with the command
	always_ff @(posedge clk125) begin
		if (cmd_take) begin
			rsp_beat.data <= dec_word;
			rsp_beat.last <= dec_last;
			rd_req.start  <= fill_start[ADDR_W:0];  // range already checked
			rd_req.count  <= fill_count[ADDR_W:0];
		end
	end

endmodule

`default_nettype wire

/* hdl/chan_cmd_pkg.sv */
`default_nettype none

package chan_cmd_pkg;

	// opcodes carried in the top nibble of every command and reply word
	typedef enum logic [3:0] {
		CMD_WR_TAG   = 4'h1,  // arg is the new channel tag
		CMD_RD_TAG   = 4'h2,
		CMD_RD_COUNT = 4'h3,  // number of bursts in the store
		CMD_RD_FILL  = 4'h4,  // arg = {start, count}
		CMD_BAD      = 4'hf   // reply only, never sent as a command
	} cmd_op_e;

	// one 32-bit command word from the receive stream
	typedef struct packed {
		cmd_op_e     op;
		logic [11:0] spare;  // ignored
		logic [15:0] arg;    // tag, or start byte over count byte for a fill
	} cmd_word_t;

	// one 32-bit reply word, also used as the fill header
	typedef struct packed {
		cmd_op_e     op;     // echoed opcode or CMD_BAD
		logic [11:0] info;   // always zero for now
		logic [15:0] value;  // tag, burst count or stored count
	} rsp_word_t;

	localparam logic [15:0] TAG_RESET = 16'h0000;

endpackage

`default_nettype wire

/* hdl/chan_data_pkg.sv */
`default_nettype none

package chan_data_pkg;

	localparam int BURST_W         = 128;                  // one stored burst
	localparam int WORD_W          = 32;                   // one link word
	localparam int WORDS_PER_BURST = BURST_W / WORD_W;     // 4 link words per burst
	localparam int STORE_DEPTH     = 64;                   // burst slots in the fill store
	localparam int ADDR_W          = $clog2(STORE_DEPTH);  // 6

	typedef logic [BURST_W-1:0] burst_t;

	// burst plus end-of-fill marker, store to narrowing stage
	typedef struct packed {
		burst_t data;
		logic   last;   // final burst of the fill read
	} burst_beat_t;

	typedef struct packed {
		logic [WORD_W-1:0] data;
		logic              last;  // final word of a reply or of a fill
	} link_beat_t;

	// one extra bit on each so a full store (64) can be described
	typedef struct packed {
		logic [ADDR_W:0] start;
		logic [ADDR_W:0] count;
	} rd_req_t;

endpackage

`default_nettype wire
